/* hw/exc_macros.svh */
`ifndef EXC_MACROS_SVH
`define EXC_MACROS_SVH

///////////////////////////////////////////////////////////////////////
// widths
///////////////////////////////////////////////////////////////////////

// mcause width, top bit flags an interrupt
`define EXC_CAUSE_W 6
// pc and handler address width
`define EXC_PC_W 32

///////////////////////////////////////////////////////////////////////
// handler layout
///////////////////////////////////////////////////////////////////////

// trap vector table base
`define EXC_VEC_BASE 32'h0000_1000
// synchronous exception slots after the irq entries
`define EXC_OFS_ILLEGAL 32'h84
`define EXC_OFS_ECALL 32'h88

// pipeline drain length before ack, must be at least 1
`define EXC_FLUSH_CYCLES 3

`endif

/* hw/exc_pkg.sv */
`include "exc_macros.svh"

package exc_pkg;

  ///////////////////////////////////////////////////////////////////////
  // core state seen by the exception path
  ///////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // flags from the id-stage decoder
  typedef struct packed {
    logic ecall;
    logic illegal;
    logic ebrk;
  } exc_event_t;

  // level-triggered interrupt line with its id
  typedef struct packed {
    logic       valid;
    logic [4:0] id;
  } irq_t;

  // debug enables, sste traps on every instruction
  typedef struct packed {
    logic sste;
    logic ecall;
    logic ebrk;
    logic eill;
    logic irq;
  } dbg_settings_t;

  ///////////////////////////////////////////////////////////////////////
  // request towards the pipeline controller
  ///////////////////////////////////////////////////////////////////////

  // handler select for the fetch redirect
  typedef enum logic [1:0] {
    PC_SEL_IRQ     = 2'd0,
    PC_SEL_ECALL   = 2'd1,
    PC_SEL_ILLEGAL = 2'd2
  } pc_sel_e;

  typedef struct packed {
    logic [`EXC_CAUSE_W-1:0] cause;
    pc_sel_e                 pc_sel;
  } exc_req_t;

  // synchronous cause codes, interrupts use {1'b1, id}
  localparam logic [`EXC_CAUSE_W-1:0] EXC_CAUSE_ILLEGAL_INSN = 6'd2;
  localparam logic [`EXC_CAUSE_W-1:0] EXC_CAUSE_BREAKPOINT   = 6'd3;
  localparam logic [`EXC_CAUSE_W-1:0] EXC_CAUSE_ECALL_UMODE  = 6'd8;
  localparam logic [`EXC_CAUSE_W-1:0] EXC_CAUSE_ECALL_MMODE  = 6'd11;

endpackage

/* hw/exc_cause_regs.sv */
`include "exc_macros.svh"

module exc_cause_regs (
  input  logic                     clk,
  input  logic                     rst_n,

  // write strobe from the exception controller
  input  logic                     save_i,

  // values captured on save
  input  logic [`EXC_CAUSE_W-1:0]  cause_i,
  input  logic [`EXC_PC_W-1:0]     epc_i,

  // software visible state
  output logic [`EXC_CAUSE_W-1:0]  mcause_o,
  output logic [`EXC_PC_W-1:0]     mepc_o
);

  ///////////////////////////////////////////////////////////////////////
  // architectural trap registers
  ///////////////////////////////////////////////////////////////////////

  logic [`EXC_CAUSE_W-1:0] mcause_q;
  logic [`EXC_PC_W-1:0]    mepc_q;

  // mcause
  // interrupt flag in the msb, id or code below
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mcause_q <= '0;
    end else if (save_i) begin
      mcause_q <= cause_i;
    end
  end

  // mepc
  // pc of the instruction in id when the trap is taken
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mepc_q <= '0;
    end else if (save_i) begin
      mepc_q <= epc_i;
    end
  end

  // new values show up together with the redirect
  assign mcause_o = mcause_q;
  assign mepc_o   = mepc_q;

endmodule

/* hw/pipe_flush_ctrl.sv */
`include "exc_macros.svh"

module pipe_flush_ctrl (
  input  logic                     clk,
  input  logic                     rst_n,

  // request side from the exception controller
  input  logic                     int_req_i,
  input  logic                     ext_req_i,
  input  exc_pkg::exc_req_t        req_info_i,
  output logic                     ack_o,

  // fetch redirect
  output logic                     redirect_valid_o,
  output logic [`EXC_PC_W-1:0]     redirect_pc_o
);

  // counter must hold EXC_FLUSH_CYCLES-1
  localparam int CNT_W = $clog2(`EXC_FLUSH_CYCLES + 1);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`EXC_FLUSH_CYCLES - 1);

  typedef enum logic {
    FLUSH_IDLE,
    FLUSH_DRAIN
  } flush_state_e;

  flush_state_e            state_q;
  logic [CNT_W-1:0]        cnt_q;
  logic                    req;
  logic [`EXC_PC_W-1:0]    handler_pc;
  logic                    redirect_valid_q;
  logic [`EXC_PC_W-1:0]    redirect_pc_q;

  ///////////////////////////////////////////////////////////////////////
  // drain sequencing
  ///////////////////////////////////////////////////////////////////////

  assign req = int_req_i | ext_req_i;

  // ack in the last drain cycle
  assign ack_o = (state_q == FLUSH_DRAIN) && (cnt_q == CNT_LAST);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= FLUSH_IDLE;
      cnt_q   <= '0;
    end else begin
      unique case (state_q)
        FLUSH_IDLE: begin
          if (req) begin
            state_q <= FLUSH_DRAIN;
            cnt_q   <= '0;
          end
        end
        FLUSH_DRAIN: begin
          if (ack_o) begin
            state_q <= FLUSH_IDLE;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        default: begin
          state_q <= FLUSH_IDLE;
        end
      endcase
    end
  end

  ///////////////////////////////////////////////////////////////////////
  // handler address
  ///////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (req_info_i.pc_sel)
      // one word per interrupt id
      exc_pkg::PC_SEL_IRQ:
        handler_pc = `EXC_VEC_BASE + (`EXC_PC_W'(req_info_i.cause[4:0]) << 2);
      exc_pkg::PC_SEL_ECALL:
        handler_pc = `EXC_VEC_BASE + `EXC_OFS_ECALL;
      exc_pkg::PC_SEL_ILLEGAL:
        handler_pc = `EXC_VEC_BASE + `EXC_OFS_ILLEGAL;
      default:
        handler_pc = `EXC_VEC_BASE;
    endcase
  end

  // one-cycle redirect pulse after ack
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      redirect_valid_q <= 1'b0;
    end else begin
      redirect_valid_q <= ack_o;
    end
  end

  // req_info is stable through ack
  always_ff @(posedge clk) begin
    if (ack_o) begin
      redirect_pc_q <= handler_pc;
    end
  end

  assign redirect_valid_o = redirect_valid_q;
  assign redirect_pc_o    = redirect_pc_q;

endmodule

/* hw/exc_controller.sv */
module exc_controller #(
  // user-mode ecall gets its own cause code
  parameter bit SECURE = 1'b0
) (
  input  logic                     clk,
  input  logic                     rst_n,

  // decoder flags and interrupt line
  input  exc_pkg::exc_event_t      ev_i,
  input  exc_pkg::irq_t            irq_i,
  input  logic                     irq_enable_i,

  // core state and debug enables
  input  exc_pkg::priv_lvl_e       priv_i,
  input  exc_pkg::dbg_settings_t   dbg_i,

  // req/ack pair with the pipeline controller
  input  logic                     ack_i,
  output logic                     int_req_o,
  output logic                     ext_req_o,
  output exc_pkg::exc_req_t        req_info_o,
  output logic                     save_cause_o,

  // towards the debug unit
  output logic                     trap_o
);

  typedef enum logic [1:0] {
    EXC_IDLE,
    EXC_WAIT_INT,
    EXC_WAIT_EXT
  } exc_state_e;

  exc_state_e         state_q, state_d;

  logic               irq_pending;
  logic               int_req_raw;
  logic               ext_req_raw;
  logic               new_req;

  exc_pkg::exc_req_t  req_info_d;
  exc_pkg::exc_req_t  req_info_q;

  ///////////////////////////////////////////////////////////////////////
  // debug trap and raw requests
  ///////////////////////////////////////////////////////////////////////

  assign irq_pending = irq_i.valid & irq_enable_i;

  // any enabled source halts into debug
  assign trap_o = dbg_i.sste
                | (ev_i.ecall   & dbg_i.ecall)
                | (ev_i.ebrk    & dbg_i.ebrk)
                | (ev_i.illegal & dbg_i.eill)
                | (irq_pending  & dbg_i.irq);

  // ebreak raises no request on its own
  assign int_req_raw = ev_i.ecall | ev_i.illegal;
  assign ext_req_raw = irq_pending;

  assign new_req = (state_q == EXC_IDLE) && (int_req_raw || ext_req_raw);

  ///////////////////////////////////////////////////////////////////////
  // cause and handler choice
  ///////////////////////////////////////////////////////////////////////

  always_comb begin
    req_info_d.cause  = '0;
    req_info_d.pc_sel = exc_pkg::PC_SEL_IRQ;

    // interrupt first and any exception below overrides it
    if (irq_pending) begin
      req_info_d.cause = {1'b1, irq_i.id};
    end

    // ebreak sets only the cause and keeps the handler
    if (ev_i.ebrk) begin
      req_info_d.cause = exc_pkg::EXC_CAUSE_BREAKPOINT;
    end

    if (ev_i.ecall) begin
      if (SECURE && (priv_i == exc_pkg::PRIV_LVL_U)) begin
        req_info_d.cause = exc_pkg::EXC_CAUSE_ECALL_UMODE;
      end else begin
        req_info_d.cause = exc_pkg::EXC_CAUSE_ECALL_MMODE;
      end
      req_info_d.pc_sel = exc_pkg::PC_SEL_ECALL;
    end else if (ev_i.illegal) begin
      req_info_d.cause  = exc_pkg::EXC_CAUSE_ILLEGAL_INSN;
      req_info_d.pc_sel = exc_pkg::PC_SEL_ILLEGAL;
    end
  end

  // captured on the first request cycle and held until ack
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_info_q <= '0;
    end else if (new_req) begin
      req_info_q <= req_info_d;
    end
  end

  // bypass while idle so the request carries its cause right away
  assign req_info_o = new_req ? req_info_d : req_info_q;

  ///////////////////////////////////////////////////////////////////////
  // request fsm
  ///////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    int_req_o    = 1'b0;
    ext_req_o    = 1'b0;
    save_cause_o = 1'b0;

    unique case (state_q)
      EXC_IDLE: begin
        int_req_o = int_req_raw;
        ext_req_o = ext_req_raw;
        // exception wins the wait state
        if (int_req_raw) begin
          state_d = EXC_WAIT_INT;
        end else if (ext_req_raw) begin
          state_d = EXC_WAIT_EXT;
        end
        if ((int_req_raw || ext_req_raw) && ack_i) begin
          save_cause_o = 1'b1;
          state_d      = EXC_IDLE;
        end
      end

      EXC_WAIT_INT: begin
        int_req_o = 1'b1;
        if (ack_i) begin
          save_cause_o = 1'b1;
          state_d      = EXC_IDLE;
        end
      end

      // held even if the irq line dropped meanwhile
      EXC_WAIT_EXT: begin
        ext_req_o = 1'b1;
        if (ack_i) begin
          save_cause_o = 1'b1;
          state_d      = EXC_IDLE;
        end
      end

      default: begin
        state_d = EXC_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= EXC_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

/* hw/exc_unit_top.sv */
`include "exc_macros.svh"

module exc_unit_top #(
  parameter bit SECURE = 1'b0
) (
  input  logic                     clk,
  input  logic                     rst_n,

  // id stage
  input  exc_pkg::exc_event_t      ev_i,
  input  exc_pkg::irq_t            irq_i,
  input  logic                     irq_enable_i,
  input  exc_pkg::priv_lvl_e       priv_i,
  input  exc_pkg::dbg_settings_t   dbg_i,
  input  logic [`EXC_PC_W-1:0]     pc_id_i,

  // debug, fetch and csr side
  output logic                     trap_o,
  output logic                     redirect_valid_o,
  output logic [`EXC_PC_W-1:0]     redirect_pc_o,
  output logic [`EXC_CAUSE_W-1:0]  mcause_o,
  output logic [`EXC_PC_W-1:0]     mepc_o
);

  // req/ack between decision and drain
  logic               int_req;
  logic               ext_req;
  logic               ack;
  logic               save_cause;
  exc_pkg::exc_req_t  req_info;

  ///////////////////////////////////////////////////////////////////////
  // producer, buffer, consumer
  ///////////////////////////////////////////////////////////////////////

  exc_controller #(
    .SECURE (SECURE)
  ) u_exc_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .ev_i         (ev_i),
    .irq_i        (irq_i),
    .irq_enable_i (irq_enable_i),
    .priv_i       (priv_i),
    .dbg_i        (dbg_i),
    .ack_i        (ack),
    .int_req_o    (int_req),
    .ext_req_o    (ext_req),
    .req_info_o   (req_info),
    .save_cause_o (save_cause),
    .trap_o       (trap_o)
  );

  // mepc takes the id pc of the ack cycle
  exc_cause_regs u_cause_regs (
    .clk      (clk),
    .rst_n    (rst_n),
    .save_i   (save_cause),
    .cause_i  (req_info.cause),
    .epc_i    (pc_id_i),
    .mcause_o (mcause_o),
    .mepc_o   (mepc_o)
  );

  pipe_flush_ctrl u_flush (
    .clk              (clk),
    .rst_n            (rst_n),
    .int_req_i        (int_req),
    .ext_req_i        (ext_req),
    .req_info_i       (req_info),
    .ack_o            (ack),
    .redirect_valid_o (redirect_valid_o),
    .redirect_pc_o    (redirect_pc_o)
  );

endmodule

/* verif/exc_unit_tb.sv */
`include "exc_macros.svh"

module exc_unit_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 3;
  localparam int NUM_ENTRIES  = 13;
  // observation window per entry long enough to prove no redirect
  localparam int WINDOW       = `EXC_FLUSH_CYCLES + 3;
  localparam int WATCHDOG_NS  = NUM_ENTRIES * (`EXC_FLUSH_CYCLES + 6) * CLK_PERIOD
                              + (RESET_CYCLES + 20) * CLK_PERIOD;
  localparam logic [31:0] LCG_SEED = 32'hea76_0870;

  // one row of stimulus plus expected response
  typedef struct packed {
    exc_pkg::exc_event_t      ev;
    exc_pkg::irq_t            irq;
    logic                     irq_en;
    exc_pkg::priv_lvl_e       priv;
    exc_pkg::dbg_settings_t   dbg;
    logic                     drop_irq;
    logic                     exp_trap;
    logic                     exp_redirect;
    logic [`EXC_PC_W-1:0]     exp_pc;
    logic [`EXC_CAUSE_W-1:0]  exp_mcause;
  } vector_t;

  logic                     clk;
  logic                     rst_n;
  exc_pkg::exc_event_t      ev_i;
  exc_pkg::irq_t            irq_i;
  logic                     irq_enable_i;
  exc_pkg::priv_lvl_e       priv_i;
  exc_pkg::dbg_settings_t   dbg_i;
  logic [`EXC_PC_W-1:0]     pc_id_i;
  logic                     trap_o;
  logic                     redirect_valid_o;
  logic [`EXC_PC_W-1:0]     redirect_pc_o;
  logic [`EXC_CAUSE_W-1:0]  mcause_o;
  logic [`EXC_PC_W-1:0]     mepc_o;

  vector_t                  tbl [NUM_ENTRIES];
  vector_t                  tv;
  logic [31:0]              lcg_state;
  logic [`EXC_PC_W-1:0]     pc_val;
  logic [`EXC_CAUSE_W-1:0]  last_mcause;
  logic                     got_redirect;
  int                       cycles;

  exc_unit_top #(
    .SECURE (1'b1)
  ) u_dut (
    .clk              (clk),
    .rst_n            (rst_n),
    .ev_i             (ev_i),
    .irq_i            (irq_i),
    .irq_enable_i     (irq_enable_i),
    .priv_i           (priv_i),
    .dbg_i            (dbg_i),
    .pc_id_i          (pc_id_i),
    .trap_o           (trap_o),
    .redirect_valid_o (redirect_valid_o),
    .redirect_pc_o    (redirect_pc_o),
    .mcause_o         (mcause_o),
    .mepc_o           (mepc_o)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  ///////////////////////////////////////////////////////////////////////
  // helpers
  ///////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic vector_t make_vector(
    input exc_pkg::exc_event_t     ev,
    input exc_pkg::irq_t           irq,
    input logic                    en,
    input exc_pkg::priv_lvl_e      priv,
    input exc_pkg::dbg_settings_t  dbg,
    input logic                    drop,
    input logic                    trap,
    input logic                    redir,
    input logic [`EXC_PC_W-1:0]    pc,
    input logic [`EXC_CAUSE_W-1:0] cause
  );
    vector_t v;
    v.ev           = ev;
    v.irq          = irq;
    v.irq_en       = en;
    v.priv         = priv;
    v.dbg          = dbg;
    v.drop_irq     = drop;
    v.exp_trap     = trap;
    v.exp_redirect = redir;
    v.exp_pc       = pc;
    v.exp_mcause   = cause;
    return v;
  endfunction

  task automatic check_value(
    input string       name,
    input logic [31:0] exp,
    input logic [31:0] act
  );
    assert (act === exp) else begin
      $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  ///////////////////////////////////////////////////////////////////////
  // stimulus table
  ///////////////////////////////////////////////////////////////////////

  // event bits are ecall/illegal/ebrk
  // irq is {valid, id}
  // dbg bits are sste/ecall/ebrk/eill/irq
  task automatic load_table();
    // plain illegal then ecall in both modes
    tbl[0]  = make_vector(3'b010, 6'h00, 1'b0, exc_pkg::PRIV_LVL_M, 5'b00000, 1'b0,
                          1'b0, 1'b1, `EXC_VEC_BASE + `EXC_OFS_ILLEGAL, 6'd2);
    tbl[1]  = make_vector(3'b100, 6'h00, 1'b0, exc_pkg::PRIV_LVL_U, 5'b00000, 1'b0,
                          1'b0, 1'b1, `EXC_VEC_BASE + `EXC_OFS_ECALL, 6'd8);
    tbl[2]  = make_vector(3'b100, 6'h00, 1'b0, exc_pkg::PRIV_LVL_M, 5'b00000, 1'b0,
                          1'b0, 1'b1, `EXC_VEC_BASE + `EXC_OFS_ECALL, 6'd11);
    // irq id 5 enabled then id 7 masked
    tbl[3]  = make_vector(3'b000, 6'h25, 1'b1, exc_pkg::PRIV_LVL_M, 5'b00000, 1'b0,
                          1'b0, 1'b1, `EXC_VEC_BASE + 32'd20, 6'd37);
    tbl[4]  = make_vector(3'b000, 6'h27, 1'b0, exc_pkg::PRIV_LVL_M, 5'b00000, 1'b0,
                          1'b0, 1'b0, 32'h0, 6'd0);
    // exception beats interrupt
    tbl[5]  = make_vector(3'b010, 6'h23, 1'b1, exc_pkg::PRIV_LVL_M, 5'b00000, 1'b0,
                          1'b0, 1'b1, `EXC_VEC_BASE + `EXC_OFS_ILLEGAL, 6'd2);
    // ebreak alone only traps
    tbl[6]  = make_vector(3'b001, 6'h00, 1'b0, exc_pkg::PRIV_LVL_M, 5'b00100, 1'b0,
                          1'b1, 1'b0, 32'h0, 6'd0);
    tbl[7]  = make_vector(3'b100, 6'h00, 1'b0, exc_pkg::PRIV_LVL_M, 5'b01000, 1'b0,
                          1'b1, 1'b1, `EXC_VEC_BASE + `EXC_OFS_ECALL, 6'd11);
    tbl[8]  = make_vector(3'b010, 6'h00, 1'b0, exc_pkg::PRIV_LVL_M, 5'b10000, 1'b0,
                          1'b1, 1'b1, `EXC_VEC_BASE + `EXC_OFS_ILLEGAL, 6'd2);
    // irq id 9 dropping after one cycle
    tbl[9]  = make_vector(3'b000, 6'h29, 1'b1, exc_pkg::PRIV_LVL_M, 5'b00001, 1'b1,
                          1'b1, 1'b1, `EXC_VEC_BASE + 32'd36, 6'd41);
    // masked irq does not trap even with dbg.irq
    tbl[10] = make_vector(3'b000, 6'h22, 1'b0, exc_pkg::PRIV_LVL_M, 5'b00001, 1'b0,
                          1'b0, 1'b0, 32'h0, 6'd0);
    tbl[11] = make_vector(3'b010, 6'h00, 1'b0, exc_pkg::PRIV_LVL_U, 5'b00010, 1'b0,
                          1'b1, 1'b1, `EXC_VEC_BASE + `EXC_OFS_ILLEGAL, 6'd2);
    // ebreak next to an ecall leaves the ecall handler and cause
    tbl[12] = make_vector(3'b101, 6'h00, 1'b0, exc_pkg::PRIV_LVL_M, 5'b00000, 1'b0,
                          1'b0, 1'b1, `EXC_VEC_BASE + `EXC_OFS_ECALL, 6'd11);
  endtask

  ///////////////////////////////////////////////////////////////////////
  // main sequence
  ///////////////////////////////////////////////////////////////////////

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    ev_i         = '0;
    irq_i        = '0;
    irq_enable_i = 1'b0;
    priv_i       = exc_pkg::PRIV_LVL_M;
    dbg_i        = '0;
    pc_id_i      = '0;
    lcg_state    = LCG_SEED;
    last_mcause  = '0;
    load_table();

    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_value("redirect_valid_o", 32'd0, 32'(redirect_valid_o));
    check_value("mcause_o", 32'd0, 32'(mcause_o));
    check_value("mepc_o", 32'd0, mepc_o);

    for (int i = 0; i < NUM_ENTRIES; i++) begin
      tv        = tbl[i];
      lcg_state = lcg_next(lcg_state);
      pc_val    = {lcg_state[31:2], 2'b00};

      // apply on the falling edge
      @(negedge clk);
      ev_i         = tv.ev;
      irq_i        = tv.irq;
      irq_enable_i = tv.irq_en;
      priv_i       = tv.priv;
      dbg_i        = tv.dbg;
      pc_id_i      = pc_val;

      // trap is combinational so look mid drive cycle
      #1;
      check_value("trap_o", 32'(tv.exp_trap), 32'(trap_o));

      cycles       = 0;
      got_redirect = 1'b0;
      while (!got_redirect && cycles < WINDOW) begin
        @(negedge clk);
        cycles++;
        if (redirect_valid_o) begin
          got_redirect = 1'b1;
        end else if (tv.drop_irq && cycles == 1) begin
          irq_i.valid = 1'b0;
        end
      end

      if (tv.exp_redirect) begin
        assert (got_redirect) else begin
          $display("Entry %0d: no redirect seen within %0d cycles", i, WINDOW);
          $display("Simulation failed");
          $fatal(1);
        end
        check_value("redirect latency", 32'(`EXC_FLUSH_CYCLES + 1), 32'(cycles));
        check_value("redirect_pc_o", tv.exp_pc, redirect_pc_o);
        check_value("mcause_o", 32'(tv.exp_mcause), 32'(mcause_o));
        check_value("mepc_o", pc_val, mepc_o);
        last_mcause = tv.exp_mcause;
      end else begin
        assert (!got_redirect) else begin
          $display("Entry %0d: unexpected redirect after %0d cycles", i, cycles);
          $display("Simulation failed");
          $fatal(1);
        end
        // mcause left alone
        check_value("mcause_o", 32'(last_mcause), 32'(mcause_o));
      end

      // idle gap between entries
      ev_i         = '0;
      irq_i        = '0;
      irq_enable_i = 1'b0;
      dbg_i        = '0;
      repeat (2) @(negedge clk);
    end

    $display("Simulation passed");
    $finish;
  end

  // watchdog sized from the table length
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before all entries completed");
    $display("Simulation failed");
    $fatal(1);
  end

endmodule

/* exc_unit_top.f */
+incdir+hw
hw/exc_pkg.sv
hw/exc_cause_regs.sv
hw/pipe_flush_ctrl.sv
hw/exc_controller.sv
hw/exc_unit_top.sv
verif/exc_unit_tb.sv

/* Makefile */
# Verilator build and run of the exception unit testbench

VERILATOR ?= verilator
TOP       ?= exc_unit_tb
LINT_TOP  ?= exc_unit_top
FILELIST  ?= exc_unit_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "RESULT: PASS" || (echo "RESULT: FAIL"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(LINT_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
